/* flist.f */
hw/periph_pkg.sv
hw/wb_fabric.sv
hw/gpio_port.sv
hw/hex_display.sv
hw/periph_top.sv
sim/periph_checker.sv
sim/periph_tb.sv

/* hw/gpio_port.sv */
`timescale 1ns/1ps

module gpio_port
    import periph_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  wb_req_t                 req,
    output logic [31:0]             rdata,
    input  logic [GPIO_IN_NUM-1:0]  pins_in,
    output logic [GPIO_OUT_NUM-1:0] led
);

    logic [GPIO_OUT_NUM-1:0] out_q;
    logic [GPIO_IN_NUM-1:0]  sync_q1;
    logic [GPIO_IN_NUM-1:0]  sync_q2;
    logic [7:0]              ofs;
    logic                    wr;
    logic                    rd;
    logic [31:0]             byte_mask;
    logic [GPIO_OUT_NUM-1:0] wr_mask;
    logic [GPIO_OUT_NUM-1:0] wr_bits;
    logic [31:0]             rd_word;

    assign ofs = req.adr[7:0];
    assign wr  = req.stb & req.we;
    assign rd  = req.stb & ~req.we;

    assign byte_mask = sel_to_mask(req.sel);
    assign wr_mask   = byte_mask[GPIO_OUT_NUM-1:0] & GPIO_OUT_MASK;
    assign wr_bits   = req.dat[GPIO_OUT_NUM-1:0];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Output register.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_q <= '0;
        end else if (wr) begin
            if (ofs == GPIO_OUT_OFS) begin
                // Only enabled bytes of writable bits change.
                out_q <= (out_q & ~wr_mask) | (wr_bits & wr_mask);
            end else if (ofs == GPIO_TGL_OFS) begin
                out_q <= out_q ^ (wr_bits & GPIO_OUT_MASK);  // Toggle ignores sel.
            end
        end
    end

    assign led = out_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Input synchronizer.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Two flops in series. The pins are asynchronous to clk.
    always_ff @(posedge clk) begin
        sync_q1 <= pins_in;
        sync_q2 <= sync_q1;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read mux.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        case (ofs)
            GPIO_OUT_OFS: rd_word = 32'(out_q);
            GPIO_IN_OFS:  rd_word = 32'(sync_q2);
            GPIO_TGL_OFS: rd_word = 32'(out_q);  // Reads as OUT.
            default:      rd_word = '0;
        endcase
    end

    // The word is only offered while a read is strobed.
    assign rdata = rd ? rd_word : '0;

endmodule

/* hw/hex_display.sv */
`timescale 1ns/1ps

module hex_display
    import periph_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  wb_req_t     req,
    output logic [31:0] rdata,
    output seg_bus_t    hex_seg
);

    logic [HEX_DIG_BITS-1:0] dig_q;
    logic [HEX_NUM-1:0]      blank_q;
    logic [7:0]              ofs;
    logic                    wr;
    logic                    rd;
    logic [31:0]             byte_mask;
    logic [31:0]             rd_word;

    // Maps one nibble to active-low segments, a in bit 0.
    function automatic logic [6:0] seg7(input logic [3:0] nib);
        logic [6:0] on;
        case (nib)
            4'h0:    on = 7'h3F;
            4'h1:    on = 7'h06;
            4'h2:    on = 7'h5B;
            4'h3:    on = 7'h4F;
            4'h4:    on = 7'h66;
            4'h5:    on = 7'h6D;
            4'h6:    on = 7'h7D;
            4'h7:    on = 7'h07;
            4'h8:    on = 7'h7F;
            4'h9:    on = 7'h6F;
            4'hA:    on = 7'h77;
            4'hB:    on = 7'h7C;
            4'hC:    on = 7'h39;
            4'hD:    on = 7'h5E;
            4'hE:    on = 7'h79;
            default: on = 7'h71;
        endcase
        return ~on;
    endfunction

    assign ofs       = req.adr[7:0];
    assign wr        = req.stb & req.we;
    assign rd        = req.stb & ~req.we;
    assign byte_mask = sel_to_mask(req.sel);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Digit and blank registers.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dig_q   <= '0;
            blank_q <= '1;  // All digits dark out of reset.
        end else if (wr) begin
            if (ofs == HEX_DIG_OFS) begin
                dig_q <= (dig_q & ~byte_mask[HEX_DIG_BITS-1:0])
                       | (req.dat[HEX_DIG_BITS-1:0] & byte_mask[HEX_DIG_BITS-1:0]);
            end else if (ofs == HEX_BLANK_OFS) begin
                blank_q <= (blank_q & ~byte_mask[HEX_NUM-1:0])
                         | (req.dat[HEX_NUM-1:0] & byte_mask[HEX_NUM-1:0]);
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Segment decode and read mux.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        for (int i = 0; i < HEX_NUM; i++) begin
            hex_seg[i] = blank_q[i] ? 7'h7F : seg7(dig_q[4*i +: 4]);
        end
    end

    always_comb begin
        case (ofs)
            HEX_DIG_OFS:   rd_word = 32'(dig_q);
            HEX_BLANK_OFS: rd_word = 32'(blank_q);
            default:       rd_word = '0;
        endcase
    end

    assign rdata = rd ? rd_word : '0;

endmodule

/* hw/periph_pkg.sv */
package periph_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Wishbone classic request and response words.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [31:0] adr;
        logic [31:0] dat;
        logic [3:0]  sel;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic        err;
        logic [31:0] dat;
    } wb_rsp_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sizes, address map and register offsets.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int GPIO_OUT_NUM = 10;
    localparam int GPIO_IN_NUM  = 12;
    localparam int HEX_NUM      = 6;
    localparam int HEX_DIG_BITS = 4 * HEX_NUM;  // One nibble per digit.

    localparam logic [GPIO_OUT_NUM-1:0] GPIO_OUT_MASK = 10'h3FF;

    // Digit 0 sits in the low bits, segments a to g from bit 0, active low.
    typedef logic [HEX_NUM-1:0][6:0] seg_bus_t;

    localparam logic [31:0] GPIO_BASE = 32'h0000_0100;
    localparam logic [31:0] HEX_BASE  = 32'h0000_0200;
    localparam logic [31:0] WIN_MASK  = 32'hFFFF_FF00;  // Each window spans 256 bytes.

    localparam logic [7:0] GPIO_OUT_OFS  = 8'h00;
    localparam logic [7:0] GPIO_IN_OFS   = 8'h04;
    localparam logic [7:0] GPIO_TGL_OFS  = 8'h08;
    localparam logic [7:0] HEX_DIG_OFS   = 8'h00;
    localparam logic [7:0] HEX_BLANK_OFS = 8'h04;

    // Expands the four byte selects into a 32-bit bit mask.
    function automatic logic [31:0] sel_to_mask(input logic [3:0] sel);
        logic [31:0] mask;
        for (int i = 0; i < 4; i++) begin
            mask[8*i +: 8] = {8{sel[i]}};
        end
        return mask;
    endfunction

endpackage

/* hw/periph_top.sv */
`timescale 1ns/1ps

module periph_top
    import periph_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  wb_req_t                 wb_req,
    output wb_rsp_t                 wb_rsp,
    input  logic [GPIO_IN_NUM-1:0]  pins_in,
    output logic [GPIO_OUT_NUM-1:0] led,
    output seg_bus_t                hex_seg
);

    wb_req_t     gpio_req;
    wb_req_t     hex_req;
    logic [31:0] gpio_rdata;
    logic [31:0] hex_rdata;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bus fabric and the two peripherals behind it.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    wb_fabric wb_fabric_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .gpio_req  (gpio_req),
        .hex_req   (hex_req),
        .gpio_rdata(gpio_rdata),
        .hex_rdata (hex_rdata)
    );

    gpio_port gpio_port_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .req    (gpio_req),
        .rdata  (gpio_rdata),
        .pins_in(pins_in),
        .led    (led)
    );

    // Six digits, driven straight from the display registers.
    hex_display hex_display_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .req    (hex_req),
        .rdata  (hex_rdata),
        .hex_seg(hex_seg)
    );

endmodule

/* hw/wb_fabric.sv */
`timescale 1ns/1ps

module wb_fabric
    import periph_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  wb_req_t     wb_req,
    output wb_rsp_t     wb_rsp,
    output wb_req_t     gpio_req,
    output wb_req_t     hex_req,
    input  logic [31:0] gpio_rdata,
    input  logic [31:0] hex_rdata
);

    logic        active;
    logic        fire;
    logic        pend;
    logic        hit_gpio;
    logic        hit_hex;
    logic        hit_any;
    logic        ack_q;
    logic        err_q;
    logic [31:0] dat_q;
    logic [31:0] sel_rdata;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Address decode.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign hit_gpio = (wb_req.adr & WIN_MASK) == GPIO_BASE;
    assign hit_hex  = (wb_req.adr & WIN_MASK) == HEX_BASE;
    assign hit_any  = hit_gpio | hit_hex;

    assign active = wb_req.cyc & wb_req.stb;
    assign fire   = active & ~pend;  // First cycle of a held request only.

    // Each peripheral sees the request, with its strobe limited to its own window.
    always_comb begin
        gpio_req     = wb_req;
        gpio_req.stb = fire & hit_gpio;
        hex_req      = wb_req;
        hex_req.stb  = fire & hit_hex;
    end

    always_comb begin
        if (hit_gpio) begin
            sel_rdata = gpio_rdata;
        end else if (hit_hex) begin
            sel_rdata = hex_rdata;
        end else begin
            sel_rdata = '0;  // A miss returns zero along with err.
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Registered response.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // The pending flag stays set until the master drops its strobe.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pend  <= 1'b0;
            ack_q <= 1'b0;
            err_q <= 1'b0;
        end else begin
            if (!active) begin
                pend <= 1'b0;
            end else if (fire) begin
                pend <= 1'b1;
            end
            ack_q <= fire & hit_any;
            err_q <= fire & ~hit_any;
        end
    end

    always_ff @(posedge clk) begin
        dat_q <= fire ? sel_rdata : '0;
    end

    assign wb_rsp = '{ack: ack_q, err: err_q, dat: dat_q};

endmodule

/* run.sh */
#!/bin/sh
# Build with Verilator, run the testbench, then look for the pass line in the log.
rm -f sim.log
verilator --binary --timing --assert --top-module periph_tb -f flist.f \
    && ./obj_dir/Vperiph_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "=== PASS ===" sim.log && echo "simulation passed" && exit 0 \
    || { echo "simulation failed"; exit 1; }

/* sim/periph_checker.sv */
`timescale 1ns/1ps

module periph_checker
    import periph_pkg::*;
(
    input logic    clk,
    input logic    rst_n,
    input wb_req_t wb_req,
    input wb_rsp_t wb_rsp
);

    logic answer;
    logic request;
    int   fail_count = 0;

    assign answer  = wb_rsp.ack | wb_rsp.err;
    assign request = wb_req.cyc & wb_req.stb;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Response protocol.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    one_kind: assert property (@(posedge clk) disable iff (!rst_n)
        !(wb_rsp.ack && wb_rsp.err))
        else begin
            $error("ack and err are high in the same cycle");
            fail_count++;
        end

    single_answer: assert property (@(posedge clk) disable iff (!rst_n)
        answer |=> !answer)  // A held request is answered once.
        else begin
            $error("bus answered in two consecutive cycles");
            fail_count++;
        end

    answer_after_request: assert property (@(posedge clk) disable iff (!rst_n)
        answer |-> $past(request))
        else begin
            $error("bus answered without a request in the cycle before");
            fail_count++;
        end

    // The first reset edge clears the response. Later reset cycles stay quiet.
    quiet_in_reset: assert property (@(posedge clk)
        (!rst_n && $past(!rst_n)) |-> !answer)
        else begin
            $error("ack or err is high while reset is asserted");
            fail_count++;
        end

endmodule

bind wb_fabric periph_checker periph_checker_inst (
    .clk   (clk),
    .rst_n (rst_n),
    .wb_req(wb_req),
    .wb_rsp(wb_rsp)
);

/* sim/periph_tb.sv */
`timescale 1ns/1ps

module periph_tb
    import periph_pkg::*;
;

    localparam int MAX_CYCLES   = 4000;
    localparam int ANSWER_LIMIT = 8;

    logic                    clk = 1'b0;
    logic                    rst_n;
    wb_req_t                 wb_req;
    wb_rsp_t                 wb_rsp;
    logic [GPIO_IN_NUM-1:0]  pins_in;
    logic [GPIO_OUT_NUM-1:0] led;
    seg_bus_t                hex_seg;

    logic [31:0]             seed = 32'd45975;
    logic [GPIO_OUT_NUM-1:0] out_m;    // Model of the OUT register.
    logic [4*HEX_NUM-1:0]    dig_m;
    logic [HEX_NUM-1:0]      blank_m;
    logic [31:0]             r;
    logic [31:0]             d;
    logic [31:0]             rd;
    logic [3:0]              sel;
    logic [7:0]              ofs;
    wb_rsp_t                 rsp;
    string                   test_name;
    int                      checks = 0;
    int                      errors = 0;
    int                      test_errors = 0;
    int                      lat_errors = 0;
    int                      asrt_fails = 0;
    int                      cycles = 0;

    periph_top periph_top_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp),
        .pins_in(pins_in),
        .led    (led),
        .hex_seg(hex_seg)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("TIMEOUT: run did not end within %0d cycles", MAX_CYCLES);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus source and reference model.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed ^ (seed >> 16);  // Folds the better high bits down.
    endfunction

    // Segments are active low. Bit 6 is segment g and bit 0 is segment a.
    function automatic logic [6:0] seg7_ref(input logic [3:0] nib);
        logic [6:0] seg;
        case (nib)
            4'h0:    seg = 7'b1000000;
            4'h1:    seg = 7'b1111001;
            4'h2:    seg = 7'b0100100;
            4'h3:    seg = 7'b0110000;
            4'h4:    seg = 7'b0011001;
            4'h5:    seg = 7'b0010010;
            4'h6:    seg = 7'b0000010;
            4'h7:    seg = 7'b1111000;
            4'h8:    seg = 7'b0000000;
            4'h9:    seg = 7'b0010000;
            4'hA:    seg = 7'b0001000;
            4'hB:    seg = 7'b0000011;
            4'hC:    seg = 7'b1000110;
            4'hD:    seg = 7'b0100001;
            4'hE:    seg = 7'b0000110;
            default: seg = 7'b0001110;
        endcase
        return seg;
    endfunction

    function automatic seg_bus_t hex_ref(input logic [4*HEX_NUM-1:0] dig,
                                         input logic [HEX_NUM-1:0] blank);
        seg_bus_t seg;
        for (int i = 0; i < HEX_NUM; i++) begin
            seg[i] = blank[i] ? 7'h7F : seg7_ref(dig[4*i +: 4]);
        end
        return seg;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bus access and comparison.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic compare(input string what, input logic [63:0] exp, input logic [63:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            test_errors++;
            $display("MISMATCH %s %s expected 0x%0h actual 0x%0h", test_name, what, exp, act);
        end
    endtask

    task automatic finish_test();
        $display("test %-9s done, %0d errors", test_name, test_errors);
        test_errors = 0;
    endtask

    task automatic bus_cycle(input logic we, input logic [31:0] adr, input logic [31:0] dat,
                             input logic [3:0] bsel, output wb_rsp_t ans);
        int waited;
        waited = 0;
        @(posedge clk);
        wb_req.cyc <= 1'b1;
        wb_req.stb <= 1'b1;
        wb_req.we  <= we;
        wb_req.adr <= adr;
        wb_req.dat <= dat;
        wb_req.sel <= bsel;
        do begin
            @(posedge clk);
            waited++;
            @(negedge clk);  // Outputs are settled here.
        end while (!(wb_rsp.ack || wb_rsp.err) && waited < ANSWER_LIMIT);
        ans = wb_rsp;
        checks++;
        if (!(ans.ack || ans.err)) begin
            errors++;
            lat_errors++;
            $display("%s: no ack or err within %0d cycles at address 0x%08h",
                     test_name, ANSWER_LIMIT, adr);
        end else if (waited != 1) begin
            errors++;
            lat_errors++;
            $display("%s: answer came %0d cycles after the request instead of 1",
                     test_name, waited);
        end
        @(posedge clk);
        wb_req.cyc <= 1'b0;
        wb_req.stb <= 1'b0;
        wb_req.we  <= 1'b0;
    endtask

    task automatic bus_write(input logic [31:0] adr, input logic [31:0] dat,
                             input logic [3:0] bsel);
        wb_rsp_t ans;
        bus_cycle(1'b1, adr, dat, bsel, ans);
        compare("write ack", 64'd1, 64'(ans.ack));
    endtask

    task automatic bus_read(input logic [31:0] adr, output logic [31:0] dat);
        wb_rsp_t ans;
        bus_cycle(1'b0, adr, 32'd0, 4'hF, ans);
        compare("read ack", 64'd1, 64'(ans.ack));
        dat = ans.dat;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Test sequence.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        rst_n   <= 1'b0;
        wb_req  <= '0;
        pins_in <= '0;
        out_m   = '0;
        dig_m   = '0;
        blank_m = '1;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        test_name = "reset";
        @(negedge clk);
        compare("ack,err", 64'd0, 64'({wb_rsp.ack, wb_rsp.err}));
        compare("led", 64'd0, 64'(led));
        compare("hex_seg", 64'({42{1'b1}}), 64'(hex_seg));
        finish_test();

        test_name = "gpio_out";
        for (int i = 0; i < 40; i++) begin
            r = next_rand();
            d = next_rand();
            sel = r[7:4];
            if (r[3:0] < 4'd4) begin
                ofs = GPIO_TGL_OFS;
                out_m = out_m ^ (d[GPIO_OUT_NUM-1:0] & GPIO_OUT_MASK);
            end else begin
                ofs = GPIO_OUT_OFS;
                for (int b = 0; b < GPIO_OUT_NUM; b++) begin
                    if (sel[b/8] && GPIO_OUT_MASK[b]) out_m[b] = d[b];
                end
            end
            bus_write({GPIO_BASE[31:8], ofs}, d, sel);
            compare("led", 64'(out_m), 64'(led));
            bus_read({GPIO_BASE[31:8], ofs}, rd);  // TGL reads back as OUT.
            compare("read back", 64'(out_m), 64'(rd));
        end
        finish_test();

        test_name = "gpio_in";
        for (int i = 0; i < 12; i++) begin
            r = next_rand();
            @(posedge clk);
            pins_in <= r[GPIO_IN_NUM-1:0];
            repeat (4) @(posedge clk);
            bus_read({GPIO_BASE[31:8], GPIO_IN_OFS}, rd);
            compare("IN", 64'(r[GPIO_IN_NUM-1:0]), 64'(rd));
        end
        finish_test();

        test_name = "display";
        for (int i = 0; i < 40; i++) begin
            r = next_rand();
            d = next_rand();
            sel = r[7:4];
            if (r[0]) begin
                ofs = HEX_DIG_OFS;
                for (int b = 0; b < 4*HEX_NUM; b++) begin
                    if (sel[b/8]) dig_m[b] = d[b];
                end
            end else begin
                ofs = HEX_BLANK_OFS;
                for (int b = 0; b < HEX_NUM; b++) begin
                    if (sel[b/8]) blank_m[b] = d[b];
                end
            end
            bus_write({HEX_BASE[31:8], ofs}, d, sel);
            compare("hex_seg", 64'(hex_ref(dig_m, blank_m)), 64'(hex_seg));
            bus_read({HEX_BASE[31:8], HEX_DIG_OFS}, rd);
            compare("DIG", 64'(dig_m), 64'(rd));
            bus_read({HEX_BASE[31:8], HEX_BLANK_OFS}, rd);
            compare("BLANK", 64'(blank_m), 64'(rd));
        end
        finish_test();

        test_name = "addr_err";
        for (int i = 0; i < 4; i++) begin
            case (i)
                0:       d = 32'h0000_0000;
                1:       d = 32'h0000_0300;
                2:       d = 32'hFFFF_0100;
                default: d = 32'h1000_0204;
            endcase
            bus_cycle(1'b1, d, next_rand(), 4'hF, rsp);
            compare("miss ack,err", 64'h1, 64'({rsp.ack, rsp.err}));
            compare("led", 64'(out_m), 64'(led));
            compare("hex_seg", 64'(hex_ref(dig_m, blank_m)), 64'(hex_seg));
        end
        for (int i = 0; i < 4; i++) begin
            case (i)
                0:       d = {GPIO_BASE[31:8], 8'h0C};
                1:       d = {GPIO_BASE[31:8], 8'h80};
                2:       d = {HEX_BASE[31:8], 8'h08};
                default: d = {HEX_BASE[31:8], 8'hF0};
            endcase
            bus_cycle(1'b0, d, 32'd0, 4'hF, rsp);
            compare("unused ack,err", 64'h2, 64'({rsp.ack, rsp.err}));
            compare("unused data", 64'd0, 64'(rsp.dat));
        end
        finish_test();

        test_name = "latency";
        test_errors = lat_errors;
        finish_test();

        asrt_fails = periph_top_inst.wb_fabric_inst.periph_checker_inst.fail_count;
        $display("checks %0d, errors %0d, assertion failures %0d", checks, errors, asrt_fails);
        if (errors == 0 && asrt_fails == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
